/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_alu
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* alu_arith_unit.sv */
// combinational add, subtract, increment, decrement and compare with their flags
`timescale 1ns/1ns

module alu_arith_unit #(
    parameter int WIDTH = 4
) (
    input  alu_pkg::alu_ctrl_t  ctrl,
    input  logic [WIDTH-1:0]    opa,
    input  logic [WIDTH-1:0]    opb,
    output logic [2*WIDTH:0]    res,
    output alu_pkg::alu_flags_t flags
);
    logic [WIDTH:0] sum; // one bit wider than the operands

    always_comb begin
        sum   = '0;
        flags = '0;
        case (ctrl.cmd)
            alu_pkg::ar_add: begin
                sum        = opa + opb;
                flags.cout = sum[WIDTH];
            end
            alu_pkg::ar_add_cin: begin
                sum        = opa + opb + ctrl.cin;
                flags.cout = sum[WIDTH];
            end
            alu_pkg::ar_sub: begin
                sum         = opa - opb; // wraps in WIDTH+1 bits
                flags.oflow = opa < opb;
            end
            alu_pkg::ar_sub_cin: begin
                sum         = opa - opb - ctrl.cin;
                flags.oflow = (opa < opb) || ((opa == opb) && ctrl.cin);
            end
            alu_pkg::ar_inc_a: begin
                sum        = opa + 1'b1;
                flags.cout = sum[WIDTH];
            end
            alu_pkg::ar_dec_a: begin
                sum         = opa - 1'b1;
                flags.oflow = opa == '0;
            end
            alu_pkg::ar_inc_b: begin
                sum        = opb + 1'b1;
                flags.cout = sum[WIDTH];
            end
            alu_pkg::ar_dec_b: begin
                sum         = opb - 1'b1;
                flags.oflow = opb == '0;
            end
            alu_pkg::ar_cmp: begin // result stays zero
                flags.g = opa > opb;
                flags.e = opa == opb;
                flags.l = opa < opb;
            end
            default: sum = '0;
        endcase
    end

    assign res = {{WIDTH{1'b0}}, sum};

endmodule

/* alu_checker.sv */
// handshake and result assertions for the ALU top level, attached to every alu_top by bind
`timescale 1ns/1ns

module alu_checker #(
    parameter int WIDTH = 4
) (
    input logic                CLK,
    input logic                RST,
    input logic                req,
    input logic                ack,
    input logic [2*WIDTH:0]    res,
    input alu_pkg::alu_flags_t flags
);

    ack_rises_with_req: assert property (@(posedge CLK) disable iff (RST) $rose(ack) |-> req)
        else $error("ack rose while req was low");

    ack_held_by_req: assert property (@(posedge CLK) disable iff (RST) (ack && req) |=> ack)
        else $error("ack dropped while req was still high");

    result_stable: assert property (@(posedge CLK) disable iff (RST)
        ack |=> ($stable(res) && $stable(flags))) // held for the whole ack phase
        else $error("res or flags changed while ack was high");

    err_zero_result: assert property (@(posedge CLK) disable iff (RST) flags.err |-> (res == '0))
        else $error("err flag set with a nonzero result");

endmodule

bind alu_top alu_checker #(.WIDTH(WIDTH)) i_checker (
    .CLK(CLK), .RST(RST), .req(req), .ack(ack), .res(res), .flags(flags)
);

/* alu_ctrl_fsm.sv */
// request/ack controller that captures a request, times its execution and holds the result
`timescale 1ns/1ns

module alu_ctrl_fsm #(
    parameter int WIDTH      = 4,
    parameter int MUL_STAGES = 2
) (
    input  logic                               CLK,
    input  logic                               RST,
    input  logic                               req,
    output logic                               ack,
    input  alu_pkg::alu_ctrl_t                 ctrl,
    input  logic [WIDTH-1:0]                   opa,
    input  logic [WIDTH-1:0]                   opb,
    output alu_pkg::alu_ctrl_t                 cur_ctrl,
    output logic [WIDTH-1:0]                   cur_opa,
    output logic [WIDTH-1:0]                   cur_opb,
    output logic                               timer_load,
    output logic [$clog2(MUL_STAGES + 1)-1:0]  timer_len,
    input  logic                               expired,
    input  logic [2*WIDTH:0]                   arith_res,
    input  alu_pkg::alu_flags_t                arith_flags,
    input  logic [2*WIDTH:0]                   mul_res,
    input  logic                               mul_oflow,
    input  logic [2*WIDTH:0]                   logic_res,
    output logic [2*WIDTH:0]                   res,
    output alu_pkg::alu_flags_t                flags
);
    localparam int LEN_W = $clog2(MUL_STAGES + 1);

    typedef enum logic [1:0] {st_idle, st_exec, st_ack} state_e;

    state_e              state;
    alu_pkg::alu_class_e req_class;
    alu_pkg::alu_class_e cur_class;
    logic [2*WIDTH:0]    sel_res;
    alu_pkg::alu_flags_t sel_flags;

    assign req_class  = alu_pkg::classify(ctrl);
    assign timer_load = (state == st_idle) && req; // capture edge
    assign timer_len  = (req_class == alu_pkg::cls_mul) ? LEN_W'(MUL_STAGES) : LEN_W'(1);

    always_comb begin
        sel_res   = '0;
        sel_flags = '0;
        case (cur_class)
            alu_pkg::cls_arith: begin
                sel_res   = arith_res;
                sel_flags = arith_flags;
            end
            alu_pkg::cls_mul: begin
                sel_res         = mul_res;
                sel_flags.oflow = mul_oflow;
            end
            alu_pkg::cls_logic: sel_res = logic_res;
            default: sel_flags.err = 1'b1; // zero result, err only
        endcase
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state     <= st_idle;
            cur_class <= alu_pkg::cls_invalid;
            cur_ctrl  <= '0;
            ack       <= 1'b0;
            res       <= '0;
            flags     <= '0;
        end else begin
            case (state)
                st_idle: if (req) begin
                    cur_ctrl  <= ctrl;
                    cur_class <= req_class;
                    state     <= st_exec;
                end
                st_exec: if (expired) begin
                    res   <= sel_res;
                    flags <= sel_flags;
                    ack   <= 1'b1;
                    state <= st_ack;
                end
                st_ack: if (!req) begin // requester released
                    ack   <= 1'b0;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (timer_load) begin
            cur_opa <= opa;
            cur_opb <= opb;
        end
    end

endmodule

/* alu_latency_timer.sv */
// execution latency timer, loaded by the controller at capture and pulsing when done
`timescale 1ns/1ns

module alu_latency_timer #(
    parameter int MAX_LEN = 2
) (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic                            load,
    input  logic [$clog2(MAX_LEN + 1)-1:0]  len,
    output logic                            expired
);
    localparam int LEN_W = $clog2(MAX_LEN + 1);

    logic [LEN_W-1:0] cnt;
    logic             running;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            cnt     <= '0;
            running <= 1'b0;
        end else if (load) begin
            cnt     <= len;
            running <= 1'b1;
        end else if (running) begin
            if (cnt == '0) begin
                running <= 1'b0; // single cycle pulse
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    assign expired = running && (cnt == '0);

endmodule

/* alu_logic_unit.sv */
// combinational bitwise operations and single-bit shifts, zero-extended to the result
`timescale 1ns/1ns

module alu_logic_unit #(
    parameter int WIDTH = 4
) (
    input  alu_pkg::alu_ctrl_t ctrl,
    input  logic [WIDTH-1:0]   opa,
    input  logic [WIDTH-1:0]   opb,
    output logic [2*WIDTH:0]   res
);
    logic [WIDTH-1:0] r;

    always_comb begin
        case (ctrl.cmd)
            alu_pkg::lg_and:    r = opa & opb;
            alu_pkg::lg_nand:   r = ~(opa & opb);
            alu_pkg::lg_or:     r = opa | opb;
            alu_pkg::lg_nor:    r = ~(opa | opb);
            alu_pkg::lg_xor:    r = opa ^ opb;
            alu_pkg::lg_xnor:   r = ~(opa ^ opb);
            alu_pkg::lg_not_a:  r = ~opa;
            alu_pkg::lg_not_b:  r = ~opb;
            alu_pkg::lg_shr1_a: r = opa >> 1;
            alu_pkg::lg_shl1_a: r = opa << 1; // top bit dropped
            alu_pkg::lg_shr1_b: r = opb >> 1;
            alu_pkg::lg_shl1_b: r = opb << 1;
            default:            r = '0;
        endcase
    end

    assign res = {{(WIDTH + 1){1'b0}}, r};

endmodule

/* alu_mul_unit.sv */
// multiply operand preparation followed by a pipeline of MUL_STAGES product registers
`timescale 1ns/1ns

module alu_mul_unit #(
    parameter int WIDTH      = 4,
    parameter int MUL_STAGES = 2
) (
    input  logic               CLK,
    input  logic               RST,
    input  alu_pkg::alu_ctrl_t ctrl,
    input  logic [WIDTH-1:0]   opa,
    input  logic [WIDTH-1:0]   opb,
    output logic [2*WIDTH:0]   res,
    output logic               oflow
);
    logic [WIDTH:0]                      mul_a;
    logic [WIDTH:0]                      mul_b;
    logic [2*WIDTH:0]                    prod;
    logic [MUL_STAGES-1:0][2*WIDTH:0]    stage_q; // index 0 is the first stage

    always_comb begin
        mul_a = '0;
        mul_b = '0;
        case (ctrl.cmd)
            alu_pkg::ar_mul_inc: begin
                mul_a = opa + 1'b1;
                mul_b = opb + 1'b1;
            end
            alu_pkg::ar_mul_shl: begin
                mul_a = {opa, 1'b0}; // msb of opa kept
                mul_b = {1'b0, opb};
            end
            default: mul_a = '0;
        endcase
        prod = mul_a * mul_b; // fits in 2*WIDTH+1 bits
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            stage_q <= '0;
        end else begin
            stage_q[0] <= prod;
            for (int i = MUL_STAGES - 1; i > 0; i--) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign res   = stage_q[MUL_STAGES-1];
    assign oflow = res > {{WIDTH{1'b0}}, {(WIDTH + 1){1'b1}}};

endmodule

/* alu_pkg.sv */
// shared ALU command codes, request and flag structs, and the command classifier
package alu_pkg;

    typedef enum logic [3:0] {
        ar_add     = 4'd0,
        ar_sub     = 4'd1,
        ar_add_cin = 4'd2,
        ar_sub_cin = 4'd3,
        ar_inc_a   = 4'd4,
        ar_dec_a   = 4'd5,
        ar_inc_b   = 4'd6,
        ar_dec_b   = 4'd7,
        ar_cmp     = 4'd8,
        ar_mul_inc = 4'd9,
        ar_mul_shl = 4'd10
    } alu_arith_cmd_e; // mode 1 codes

    typedef enum logic [3:0] {
        lg_and    = 4'd0,
        lg_nand   = 4'd1,
        lg_or     = 4'd2,
        lg_nor    = 4'd3,
        lg_xor    = 4'd4,
        lg_xnor   = 4'd5,
        lg_not_a  = 4'd6,
        lg_not_b  = 4'd7,
        lg_shr1_a = 4'd8,
        lg_shl1_a = 4'd9,
        lg_shr1_b = 4'd10,
        lg_shl1_b = 4'd11
    } alu_logic_cmd_e; // mode 0 codes

    typedef struct packed {
        logic       mode;  // 1 arith/mul, 0 logic
        logic [3:0] cmd;
        logic       cin;
        logic [1:0] valid; // bit 0 opa, bit 1 opb
    } alu_ctrl_t;

    typedef struct packed {
        logic cout;
        logic oflow;
        logic g;
        logic e;
        logic l;
        logic err;
    } alu_flags_t;

    typedef enum logic [1:0] {
        cls_arith,
        cls_mul,
        cls_logic,
        cls_invalid
    } alu_class_e;

    // unknown code or a valid mask other than the needed operands gives invalid
    function automatic alu_class_e classify(alu_ctrl_t c);
        logic [1:0] need;
        alu_class_e cls;
        need = 2'b11; // most commands use both operands
        cls  = cls_invalid;
        if (c.mode) begin
            case (c.cmd)
                ar_add, ar_sub, ar_add_cin, ar_sub_cin, ar_cmp: cls = cls_arith;
                ar_mul_inc, ar_mul_shl: cls = cls_mul;
                ar_inc_a, ar_dec_a: begin
                    cls  = cls_arith;
                    need = 2'b01;
                end
                ar_inc_b, ar_dec_b: begin
                    cls  = cls_arith;
                    need = 2'b10;
                end
                default: cls = cls_invalid;
            endcase
        end else begin
            case (c.cmd)
                lg_and, lg_nand, lg_or, lg_nor, lg_xor, lg_xnor: cls = cls_logic;
                lg_not_a, lg_shr1_a, lg_shl1_a: begin
                    cls  = cls_logic;
                    need = 2'b01;
                end
                lg_not_b, lg_shr1_b, lg_shl1_b: begin
                    cls  = cls_logic;
                    need = 2'b10;
                end
                default: cls = cls_invalid;
            endcase
        end
        if (c.valid != need) begin
            cls = cls_invalid;
        end
        return cls;
    endfunction

endpackage

/* alu_top.sv */
// pipelined ALU top level with a four-phase req/ack request interface
`timescale 1ns/1ns

module alu_top #(
    parameter int WIDTH      = 4,
    parameter int MUL_STAGES = 2
) (
    input  logic                CLK,
    input  logic                RST,
    input  logic                req,
    output logic                ack,
    input  alu_pkg::alu_ctrl_t  ctrl,
    input  logic [WIDTH-1:0]    opa,
    input  logic [WIDTH-1:0]    opb,
    output logic [2*WIDTH:0]    res,
    output alu_pkg::alu_flags_t flags
);
    localparam int LEN_W = $clog2(MUL_STAGES + 1);

    alu_pkg::alu_ctrl_t  cur_ctrl;
    logic [WIDTH-1:0]    cur_opa;
    logic [WIDTH-1:0]    cur_opb;
    logic                timer_load;
    logic [LEN_W-1:0]    timer_len;
    logic                expired;
    logic [2*WIDTH:0]    arith_res;
    alu_pkg::alu_flags_t arith_flags;
    logic [2*WIDTH:0]    mul_res;
    logic                mul_oflow;
    logic [2*WIDTH:0]    logic_res;

    alu_ctrl_fsm #(.WIDTH(WIDTH), .MUL_STAGES(MUL_STAGES)) i_ctrl (
        .CLK(CLK), .RST(RST), .req(req), .ack(ack),
        .ctrl(ctrl), .opa(opa), .opb(opb),
        .cur_ctrl(cur_ctrl), .cur_opa(cur_opa), .cur_opb(cur_opb),
        .timer_load(timer_load), .timer_len(timer_len), .expired(expired),
        .arith_res(arith_res), .arith_flags(arith_flags),
        .mul_res(mul_res), .mul_oflow(mul_oflow), .logic_res(logic_res),
        .res(res), .flags(flags)
    );

    alu_latency_timer #(.MAX_LEN(MUL_STAGES)) i_timer (
        .CLK(CLK), .RST(RST), .load(timer_load), .len(timer_len), .expired(expired)
    );

    alu_arith_unit #(.WIDTH(WIDTH)) i_arith (
        .ctrl(cur_ctrl), .opa(cur_opa), .opb(cur_opb), .res(arith_res), .flags(arith_flags)
    );

    alu_mul_unit #(.WIDTH(WIDTH), .MUL_STAGES(MUL_STAGES)) i_mul (
        .CLK(CLK), .RST(RST), .ctrl(cur_ctrl), .opa(cur_opa), .opb(cur_opb),
        .res(mul_res), .oflow(mul_oflow)
    );

    alu_logic_unit #(.WIDTH(WIDTH)) i_logic (
        .ctrl(cur_ctrl), .opa(cur_opa), .opb(cur_opb), .res(logic_res)
    );

endmodule

/* tb_alu.sv */
// testbench for alu_top: random requests over req/ack, checked against a reference model
`timescale 1ns/1ns

module tb_alu;

    localparam int W       = 4;
    localparam int RW      = 2 * W + 1;
    localparam int MASK1   = (1 << (W + 1)) - 1; // all ones in W+1 bits
    localparam int TIMEOUT = 50;

    logic                CLK;
    logic                RST;
    logic                req;
    logic                ack;
    alu_pkg::alu_ctrl_t  ctrl;
    logic [W-1:0]        opa;
    logic [W-1:0]        opb;
    logic [RW-1:0]       res;
    alu_pkg::alu_flags_t flags;

    int checks;
    int errors;
    bit timed_out;

    alu_top i_dut (
        .CLK(CLK), .RST(RST), .req(req), .ack(ack),
        .ctrl(ctrl), .opa(opa), .opb(opb), .res(res), .flags(flags)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // operands each command reads
    function automatic logic [1:0] needed_mask(input logic mode, input logic [3:0] cmd);
        if (mode) begin
            case (cmd)
                alu_pkg::ar_inc_a, alu_pkg::ar_dec_a: return 2'b01;
                alu_pkg::ar_inc_b, alu_pkg::ar_dec_b: return 2'b10;
                default: return 2'b11;
            endcase
        end
        case (cmd)
            alu_pkg::lg_not_a, alu_pkg::lg_shr1_a, alu_pkg::lg_shl1_a: return 2'b01;
            alu_pkg::lg_not_b, alu_pkg::lg_shr1_b, alu_pkg::lg_shl1_b: return 2'b10;
            default: return 2'b11;
        endcase
    endfunction

    function automatic alu_pkg::alu_ctrl_t make_ctrl(input logic mode, input logic [3:0] cmd);
        alu_pkg::alu_ctrl_t c;
        c.mode  = mode;
        c.cmd   = cmd;
        c.cin   = 1'($urandom);
        c.valid = needed_mask(mode, cmd);
        return c;
    endfunction

    function automatic alu_pkg::alu_ctrl_t make_invalid_ctrl();
        alu_pkg::alu_ctrl_t c;
        do begin
            c = alu_pkg::alu_ctrl_t'(8'($urandom));
        end while (alu_pkg::classify(c) != alu_pkg::cls_invalid);
        return c;
    endfunction

    // reference model
    function automatic void model(input alu_pkg::alu_ctrl_t c, input logic [W-1:0] a,
                                  input logic [W-1:0] b, output logic [RW-1:0] r,
                                  output alu_pkg::alu_flags_t f);
        int           ai;
        int           bi;
        int           ci;
        int           t;
        logic [W-1:0] lv;
        ai = int'(a);
        bi = int'(b);
        ci = int'(c.cin);
        t  = 0;
        lv = '0;
        r  = '0;
        f  = '0;
        case (alu_pkg::classify(c))
            alu_pkg::cls_arith: begin
                case (c.cmd)
                    alu_pkg::ar_add:     t = ai + bi;
                    alu_pkg::ar_add_cin: t = ai + bi + ci;
                    alu_pkg::ar_sub:     t = ai - bi;
                    alu_pkg::ar_sub_cin: t = ai - bi - ci;
                    alu_pkg::ar_inc_a:   t = ai + 1;
                    alu_pkg::ar_dec_a:   t = ai - 1;
                    alu_pkg::ar_inc_b:   t = bi + 1;
                    alu_pkg::ar_dec_b:   t = bi - 1;
                    default:             t = 0; // compare leaves the result at zero
                endcase
                r = RW'(t & MASK1); // wraps like a W+1 bit result
                case (c.cmd)
                    alu_pkg::ar_add, alu_pkg::ar_add_cin,
                    alu_pkg::ar_inc_a, alu_pkg::ar_inc_b: f.cout = r[W];
                    alu_pkg::ar_sub:     f.oflow = ai < bi;
                    alu_pkg::ar_sub_cin: f.oflow = (ai < bi) || (ai == bi && ci == 1);
                    alu_pkg::ar_dec_a:   f.oflow = ai == 0;
                    alu_pkg::ar_dec_b:   f.oflow = bi == 0;
                    default: begin
                        f.g = ai > bi;
                        f.e = ai == bi;
                        f.l = ai < bi;
                    end
                endcase
            end
            alu_pkg::cls_mul: begin
                if (c.cmd == alu_pkg::ar_mul_inc) begin
                    t = (ai + 1) * (bi + 1);
                end else begin
                    t = (ai * 2) * bi;
                end
                r       = RW'(t);
                f.oflow = t > MASK1;
            end
            alu_pkg::cls_logic: begin
                case (c.cmd)
                    alu_pkg::lg_and:    lv = a & b;
                    alu_pkg::lg_nand:   lv = ~(a & b);
                    alu_pkg::lg_or:     lv = a | b;
                    alu_pkg::lg_nor:    lv = ~(a | b);
                    alu_pkg::lg_xor:    lv = a ^ b;
                    alu_pkg::lg_xnor:   lv = ~(a ^ b);
                    alu_pkg::lg_not_a:  lv = ~a;
                    alu_pkg::lg_not_b:  lv = ~b;
                    alu_pkg::lg_shr1_a: lv = a >> 1;
                    alu_pkg::lg_shl1_a: lv = a << 1;
                    alu_pkg::lg_shr1_b: lv = b >> 1;
                    default:            lv = b << 1;
                endcase
                r = RW'(lv);
            end
            default: f.err = 1'b1;
        endcase
    endfunction

    task automatic wait_ack(input logic level, input string name);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        while (ack !== level && cycles < TIMEOUT) begin
            @(negedge CLK);
            cycles++;
        end
        if (ack !== level) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: ack did not go %s within %0d cycles on a %s request",
                     level ? "high" : "low", TIMEOUT, name);
        end
    endtask

    // one full four-phase transaction, req held for extra cycles after ack
    task automatic run_request(input string name, input alu_pkg::alu_ctrl_t c,
                               input logic [W-1:0] a, input logic [W-1:0] b, input int hold);
        logic [RW-1:0]       exp_res;
        alu_pkg::alu_flags_t exp_flags;
        if (timed_out) return;
        model(c, a, b, exp_res, exp_flags);
        @(posedge CLK);
        ctrl <= c;
        opa  <= a;
        opb  <= b;
        req  <= 1'b1;
        wait_ack(1'b1, name);
        if (timed_out) return;
        check({name, " res"}, 32'(exp_res), 32'(res));
        check({name, " flags"}, 32'(exp_flags), 32'(flags));
        for (int i = 0; i < hold; i++) begin
            @(negedge CLK);
            check({name, " ack held"}, 32'd1, 32'(ack));
            check({name, " res held"}, 32'(exp_res), 32'(res));
        end
        @(posedge CLK);
        req <= 1'b0;
        wait_ack(1'b0, name);
    endtask

    initial begin
        alu_pkg::alu_ctrl_t c;
        logic               mode;
        void'($urandom(17703));
        checks    = 0;
        errors    = 0;
        timed_out = 1'b0;
        RST       = 1'b1;
        req       = 1'b0;
        ctrl      = '0;
        opa       = '0;
        opb       = '0;
        repeat (8) @(posedge CLK);
        RST <= 1'b0;
        @(negedge CLK);
        check("reset ack", 32'd0, 32'(ack));
        check("reset res", 32'd0, 32'(res));
        check("reset flags", 32'd0, 32'(flags));

        for (int n = 0; n < 200; n++) begin
            c = make_ctrl(1'b1, 4'($urandom_range(0, 8)));
            run_request("arith", c, W'($urandom), W'($urandom), $urandom_range(0, 3));
        end
        for (int n = 0; n < 200; n++) begin
            c = make_ctrl(1'b0, 4'($urandom_range(0, 11)));
            run_request("logic", c, W'($urandom), W'($urandom), $urandom_range(0, 3));
        end
        for (int n = 0; n < 100; n++) begin
            c = make_ctrl(1'b1, 4'($urandom_range(9, 10)));
            run_request("mul", c, W'($urandom), W'($urandom), $urandom_range(0, 3));
        end
        for (int n = 0; n < 100; n++) begin
            c = make_invalid_ctrl();
            run_request("invalid", c, W'($urandom), W'($urandom), $urandom_range(0, 3));
        end
        for (int n = 0; n < 20; n++) begin
            mode = 1'($urandom);
            c    = make_ctrl(mode, 4'($urandom_range(0, mode ? 10 : 11)));
            run_request("backpressure", c, W'($urandom), W'($urandom), $urandom_range(4, 8));
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
alu_pkg.sv
alu_latency_timer.sv
alu_arith_unit.sv
alu_mul_unit.sv
alu_logic_unit.sv
alu_ctrl_fsm.sv
alu_top.sv
alu_checker.sv
tb_alu.sv
